/* stylerSettings.svh */
// ==========================================================
// Shared constants of the glyph styler. Bus widths, the
// register map of the AXI4-Lite slave and the phase timer
// size. Include wherever one of these values is needed.
// ==========================================================
`ifndef STYLER_SETTINGS_SVH
`define STYLER_SETTINGS_SVH

`define AXIL_ADDR_W  5
`define AXIL_DATA_W  32

`define REG_SCANLINE 5'h00  // Glyph scanline, 4 bits
`define REG_CTRL     5'h04  // Control byte
`define REG_BITMAP   5'h08  // Font row, 16 bits
`define REG_ATTR     5'h0C  // Character attributes
`define REG_RESULT   5'h10  // Styled result, read only

`define PHASE_BITS   6      // Top bit blinks text, next bit the cursor
`define CTRL_RESET   8'h3C

`endif

/* stylerPkg.sv */
// ==========================================================
// Types shared by the glyph styler blocks. Vector typedefs
// for the style registers and bus words, and the state
// enum of the AXI4-Lite slave.
// ==========================================================
`default_nettype none

`include "stylerSettings.svh"

package stylerPkg;

  typedef logic [3:0]  scanline_t;   // Row inside the 16-row cell
  typedef logic [15:0] pixelRow_t;   // Bit 15 is the leftmost pixel

  // yOffset, yScale, yMirror, xMirror, bold, inverse, hidden, blink,
  // underline, strikethru, overline from bit 0 up; the rest reserved
  typedef logic [15:0] attr_t;

  // cursorBottom, cursorTop, cursorBlink, cursorEnable,
  // lineEnable, blinkEnable from bit 0 up
  typedef logic [7:0]  ctrl_t;

  typedef logic [`AXIL_DATA_W-1:0] axilData_t;
  typedef logic [`AXIL_ADDR_W-1:0] axilAddr_t;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,   // Write handshake this cycle
    WRESP,
    READ,    // Read handshake this cycle
    RRESP
  } busState_e;

endpackage

`default_nettype wire

/* styleCfgIf.sv */
// ==========================================================
// Programmed style configuration as one bundle. The register
// bank drives it through the source modport, the styling
// datapath reads it through the sink modport.
// ==========================================================
`default_nettype none

interface styleCfgIf import stylerPkg::*; ();

  scanline_t scanline;  // Unmapped glyph scanline
  ctrl_t     ctrl;
  pixelRow_t bitmap;    // Font row as fetched
  attr_t     attr;

  modport source (
    output scanline,
    output ctrl,
    output bitmap,
    output attr
  );

  modport sink (
    input scanline,
    input ctrl,
    input bitmap,
    input attr
  );

endinterface

`default_nettype wire

/* axilSlaveFsm.sv */
// ==========================================================
// AXI4-Lite slave front end. Takes one transaction at a time,
// writes before reads, and holds B or R until the master
// accepts it. Register access is a single-cycle strobe with
// read data returned combinationally by the register bank.
// ==========================================================
`default_nettype none

module axilSlaveFsm import stylerPkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       awvalid,
  output logic       awready,
  input  axilAddr_t  awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  axilData_t  wdata,
  output logic       bvalid,
  input  logic       bready,
  output logic [1:0] bresp,
  input  logic       arvalid,
  output logic       arready,
  input  axilAddr_t  araddr,
  output logic       rvalid,
  input  logic       rready,
  output axilData_t  rdata,
  output logic [1:0] rresp,
  output logic       regWe,
  output axilAddr_t  regAddr,
  output axilData_t  regWdata,
  input  axilData_t  rdRegData
);

  localparam logic [1:0] respOkay = 2'b00;

  busState_e state;
  busState_e grant;   // Handshake taken this cycle

  // A write waits for both AW and W; a half-presented write still blocks reads
  always_comb begin
    grant = IDLE;
    if (state == IDLE) begin
      if (awvalid && wvalid) begin
        grant = WRITE;
      end else if (arvalid && !awvalid && !wvalid) begin
        grant = READ;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    state <= (grant == WRITE) ? WRESP :
                          (grant == READ)  ? RRESP : IDLE;
        WRESP:   if (bready) state <= IDLE;
        RRESP:   if (rready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (grant == READ) begin
      rdata <= rdRegData;  // Held until rready
    end
  end

  assign awready  = (grant == WRITE);
  assign wready   = (grant == WRITE);
  assign arready  = (grant == READ);
  assign bvalid   = (state == WRESP);
  assign rvalid   = (state == RRESP);
  assign bresp    = respOkay;
  assign rresp    = respOkay;  // Unmapped reads are OKAY too

  assign regWe    = (grant == WRITE);
  assign regAddr  = (grant == WRITE) ? awaddr : araddr;
  assign regWdata = wdata;

endmodule

`default_nettype wire

/* styleRegs.sv */
// ==========================================================
// Style register bank. Four writable registers, each cut to
// its own width, plus the read-only result word. Drives the
// configuration bundle and answers register reads at once.
// ==========================================================
`default_nettype none

`include "stylerSettings.svh"

module styleRegs import stylerPkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      regWe,
  input  axilAddr_t regAddr,
  input  axilData_t regWdata,
  input  axilData_t resultWord,
  output axilData_t rdRegData,
  styleCfgIf.source cfg
);

  scanline_t scanlineReg;
  ctrl_t     ctrlReg;
  pixelRow_t bitmapReg;
  attr_t     attrReg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scanlineReg <= '0;
      ctrlReg     <= `CTRL_RESET;
      bitmapReg   <= '0;
      attrReg     <= '0;
    end else if (regWe) begin
      case (regAddr)
        `REG_SCANLINE: scanlineReg <= regWdata[$bits(scanline_t)-1:0];
        `REG_CTRL:     ctrlReg     <= regWdata[$bits(ctrl_t)-1:0];
        `REG_BITMAP:   bitmapReg   <= regWdata[$bits(pixelRow_t)-1:0];
        `REG_ATTR:     attrReg     <= regWdata[$bits(attr_t)-1:0];
        default: ;  // Result and unmapped offsets
      endcase
    end
  end

  always_comb begin
    case (regAddr)
      `REG_SCANLINE: rdRegData = axilData_t'(scanlineReg);
      `REG_CTRL:     rdRegData = axilData_t'(ctrlReg);
      `REG_BITMAP:   rdRegData = axilData_t'(bitmapReg);
      `REG_ATTR:     rdRegData = axilData_t'(attrReg);
      `REG_RESULT:   rdRegData = resultWord;
      default:       rdRegData = '0;
    endcase
  end

  assign cfg.scanline = scanlineReg;
  assign cfg.ctrl     = ctrlReg;
  assign cfg.bitmap   = bitmapReg;
  assign cfg.attr     = attrReg;

endmodule

`default_nettype wire

/* phaseTimer.sv */
// ==========================================================
// Free-running phase counter for blinking text and the
// blinking cursor. Starts at zero after reset and wraps.
// The cursor phase toggles twice as often as the text phase.
// ==========================================================
`default_nettype none

`include "stylerSettings.svh"

module phaseTimer (
  input  logic clk,
  input  logic rst_n,
  output logic blinkPhase,
  output logic cursorPhase
);

  logic [`PHASE_BITS-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;  // Wraps on overflow
    end
  end

  assign blinkPhase  = count[`PHASE_BITS-1];
  assign cursorPhase = count[`PHASE_BITS-2];

endmodule

`default_nettype wire

/* glyphStyler.sv */
// ==========================================================
// Scanline mapper and row styling datapath. Maps the glyph
// scanline to the font row to fetch, styles the font row,
// and registers both with the phases that were applied.
// Result word is {phases, mapped scanline, styled row}.
// ==========================================================
`default_nettype none

module glyphStyler import stylerPkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      blinkPhase,
  input  logic      cursorPhase,
  styleCfgIf.sink   cfg,
  output axilData_t resultWord
);

  logic yOffset, yScale, yMirror, xMirror;
  logic bold, inverse, hidden, blink;
  logic underline, strikethru, overline;
  logic cursorBottom, cursorTop, cursorBlink, cursorEnable;
  logic lineEnable, blinkEnable;

  scanline_t line;
  scanline_t mappedLine;
  pixelRow_t styledRow;
  logic      lineHit;
  logic      rowBlanked;
  logic      cursorHit;

  assign yOffset      = cfg.attr[0];
  assign yScale       = cfg.attr[1];
  assign yMirror      = cfg.attr[2];
  assign xMirror      = cfg.attr[3];
  assign bold         = cfg.attr[4];
  assign inverse      = cfg.attr[5];
  assign hidden       = cfg.attr[6];
  assign blink        = cfg.attr[7];
  assign underline    = cfg.attr[8];
  assign strikethru   = cfg.attr[9];
  assign overline     = cfg.attr[10];
  assign cursorBottom = cfg.ctrl[0];
  assign cursorTop    = cfg.ctrl[1];
  assign cursorBlink  = cfg.ctrl[2];
  assign cursorEnable = cfg.ctrl[3];
  assign lineEnable   = cfg.ctrl[4];
  assign blinkEnable  = cfg.ctrl[5];

  assign line = cfg.scanline;

  // Double-height halves: top half reads rows 0-7, bottom half 8-15
  always_comb begin
    mappedLine = yScale ? {yOffset, line[3:1]} : line;
    if (yMirror) begin
      mappedLine = ~mappedLine;  // 15 - row
    end
  end

  // Decorations and cursor follow the cell scanline, not the font row
  assign lineHit = lineEnable && ((underline  && line == 4'd14) ||
                                  (strikethru && line == 4'd7)  ||
                                  (overline   && line == 4'd0));
  assign rowBlanked = hidden || (blink && blinkEnable && blinkPhase);
  assign cursorHit  = cursorEnable && (cursorPhase || !cursorBlink) &&
                      ((cursorBottom && line >= 4'd14) || (cursorTop && line <= 4'd1));

  always_comb begin
    styledRow = cfg.bitmap;
    if (xMirror) begin
      for (int i = 0; i < $bits(pixelRow_t); i++) begin
        styledRow[i] = cfg.bitmap[$bits(pixelRow_t)-1-i];
      end
    end
    if (bold) styledRow = styledRow | (styledRow >> 1);  // Smear one pixel right
    if (lineHit) styledRow = '1;
    if (rowBlanked) styledRow = '0;
    if (inverse) styledRow = ~styledRow;
    if (cursorHit) styledRow = ~styledRow;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resultWord <= '0;
    end else begin
      resultWord <= axilData_t'({cursorPhase, blinkPhase, mappedLine, styledRow});
    end
  end

endmodule

`default_nettype wire

/* stylerTop.sv */
// ==========================================================
// Glyph styler top level. Plain AXI4-Lite slave ports; the
// slave FSM feeds the register bank, which configures the
// styling datapath. The result is read back over the bus.
// ==========================================================
`default_nettype none

module stylerTop import stylerPkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       awvalid,
  output logic       awready,
  input  axilAddr_t  awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  axilData_t  wdata,
  output logic       bvalid,
  input  logic       bready,
  output logic [1:0] bresp,
  input  logic       arvalid,
  output logic       arready,
  input  axilAddr_t  araddr,
  output logic       rvalid,
  input  logic       rready,
  output axilData_t  rdata,
  output logic [1:0] rresp
);

  logic      regWe;
  axilAddr_t regAddr;
  axilData_t regWdata;
  axilData_t rdRegData;
  axilData_t resultWord;
  logic      blinkPhase;
  logic      cursorPhase;

  styleCfgIf cfgBus ();

  axilSlaveFsm u_axilSlaveFsm (
    .clk, .rst_n,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp,
    .regWe, .regAddr, .regWdata, .rdRegData
  );

  styleRegs u_styleRegs (
    .clk, .rst_n, .regWe, .regAddr, .regWdata, .resultWord, .rdRegData,
    .cfg (cfgBus.source)
  );

  phaseTimer u_phaseTimer (.clk, .rst_n, .blinkPhase, .cursorPhase);

  glyphStyler u_glyphStyler (
    .clk, .rst_n, .blinkPhase, .cursorPhase,
    .cfg (cfgBus.sink),
    .resultWord
  );

endmodule

`default_nettype wire

/* tbStylerTop.sv */
// ==========================================================
// Testbench for the glyph styler. Drives the AXI4-Lite
// slave of the DUT, keeps a copy of the programmed registers,
// and checks every styled result against a reference model.
// Run with the file list; the run ends with a count line.
// ==========================================================
`default_nettype none

`include "stylerSettings.svh"

module tbStylerTop import stylerPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int numTransactions = 5 + 15 + 16 * 3 + 24 * 5 + 64 * 4 + 3;
  localparam int timeoutCycles   = 200 * numTransactions;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       awvalid, wvalid, bready, arvalid, rready;
  axilAddr_t  awaddr, araddr;
  axilData_t  wdata;
  logic       awready, wready, bvalid, arready, rvalid;
  logic [1:0] bresp, rresp;
  axilData_t  rdata;

  integer    seed = 32'h8c9b_9005;
  int        cycleCount = 0;
  int        checkCount = 0;
  int        errorCount = 0;
  int        transCount = 0;
  int        testNum = 0;
  int        checksAtStart, errorsAtStart;
  int        pick;
  scanline_t shScan;  // Copy of what the DUT should hold
  ctrl_t     shCtrl;
  pixelRow_t shBitmap;
  attr_t     shAttr;
  axilData_t value, heldData;
  logic      blinkPh, cursorPh;
  logic [1:0] seenBlink, seenCursor;

  always #50 clk = ~clk;

  stylerTop u_stylerTop (
    .clk, .rst_n,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp
  );

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the bus stopped answering, run stopped after %0d cycles", cycleCount);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic checkData(input string what, input axilData_t expected, input axilData_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic checkRow(input string what, input pixelRow_t expRow, input pixelRow_t gotRow,
                          input scanline_t expLine, input scanline_t gotLine);
    checkCount += 2;
    if (gotRow !== expRow) begin
      errorCount++;
      $display("** Error at %0t ns: %s row expected %h, got %h", $time, what, expRow, gotRow);
    end
    if (gotLine !== expLine) begin
      errorCount++;
      $display("** Error at %0t ns: %s scanline expected %0d, got %0d",
               $time, what, expLine, gotLine);
    end
  endtask

  task automatic axiWrite(input axilAddr_t addr, input axilData_t data);
    @(posedge clk);
    #10;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    #10;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    checkData("bresp", '0, axilData_t'(bresp));
    @(posedge clk);
    #10;
    bready = 1'b0;
    transCount++;
  endtask

  task automatic axiRead(input axilAddr_t addr, output axilData_t data);
    @(posedge clk);
    #10;
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #10;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    checkData("rresp", '0, axilData_t'(rresp));
    @(posedge clk);
    #10;
    rready = 1'b0;
    transCount++;
  endtask

  // Write and track what each register keeps of the word
  task automatic writeReg(input axilAddr_t addr, input axilData_t data);
    axiWrite(addr, data);
    case (addr)
      `REG_SCANLINE: shScan   = scanline_t'(data);
      `REG_CTRL:     shCtrl   = ctrl_t'(data);
      `REG_BITMAP:   shBitmap = pixelRow_t'(data);
      `REG_ATTR:     shAttr   = attr_t'(data);
      default: ;
    endcase
  endtask

  task automatic checkReg(input string what, input axilAddr_t addr, input axilData_t expected);
    axilData_t got;
    axiRead(addr, got);
    checkData(what, expected, got);
  endtask

  task automatic modelResult(input scanline_t line, input ctrl_t ctrl, input pixelRow_t bitmap,
                             input attr_t attr, input logic blinkP, input logic cursorP,
                             output pixelRow_t row, output scanline_t mapped);
    int m;
    m = line;
    if (attr[1]) m = line / 2 + (attr[0] ? 8 : 0);  // Double height
    if (attr[2]) m = 15 - m;
    mapped = scanline_t'(m);
    row = bitmap;
    if (attr[3]) begin
      for (int i = 0; i < 16; i++) row[i] = bitmap[15 - i];
    end
    if (attr[4]) row = row | (row >> 1);
    if (ctrl[4] && ((attr[8] && line == 14) || (attr[9] && line == 7) ||
                    (attr[10] && line == 0))) row = 16'hFFFF;
    if (attr[6] || (attr[7] && ctrl[5] && blinkP)) row = 16'h0000;
    if (attr[5]) row = ~row;
    if (ctrl[3] && (cursorP || !ctrl[2]) &&
        ((ctrl[0] && (line == 14 || line == 15)) || (ctrl[1] && (line == 0 || line == 1))))
      row = ~row;
  endtask

  // Model takes the phases from the returned word
  task automatic checkResult(output logic blinkP, output logic cursorP);
    axilData_t word;
    pixelRow_t expRow;
    scanline_t expLine;
    axiRead(`REG_RESULT, word);
    blinkP  = word[20];
    cursorP = word[21];
    modelResult(shScan, shCtrl, shBitmap, shAttr, blinkP, cursorP, expRow, expLine);
    checkRow("result", expRow, word[15:0], expLine, word[19:16]);
    checkData("result spare bits", '0, word & 32'hFFC0_0000);
  endtask

  task automatic beginTest();
    testNum++;
    checksAtStart = checkCount;
    errorsAtStart = errorCount;
  endtask

  task automatic endTest(input string name);
    $display("Test %0d %s finished: %0d checks, %0d errors", testNum, name,
             checkCount - checksAtStart, errorCount - errorsAtStart);
  endtask

  initial begin
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    shScan = '0;
    shCtrl = `CTRL_RESET;
    shBitmap = '0;
    shAttr = '0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;

    beginTest();
    checkReg("reset result", `REG_RESULT, '0);  // Timer phases still low this early
    checkReg("reset scanline", `REG_SCANLINE, '0);
    checkReg("reset ctrl", `REG_CTRL, 32'h0000_003C);
    checkReg("reset bitmap", `REG_BITMAP, '0);
    checkReg("reset attr", `REG_ATTR, '0);
    endTest("reset values");

    beginTest();
    value = $random(seed);
    writeReg(`REG_SCANLINE, value);
    checkReg("scanline", `REG_SCANLINE, value & 32'h0000_000F);
    value = $random(seed);
    writeReg(`REG_CTRL, value);
    checkReg("ctrl", `REG_CTRL, value & 32'h0000_00FF);
    value = $random(seed);
    writeReg(`REG_BITMAP, value);
    checkReg("bitmap", `REG_BITMAP, value & 32'h0000_FFFF);
    value = $random(seed);
    writeReg(`REG_ATTR, value);
    checkReg("attr", `REG_ATTR, value & 32'h0000_FFFF);
    checkReg("unmapped 0x14", 5'h14, '0);
    checkReg("unmapped 0x1C", 5'h1C, '0);
    writeReg(`REG_RESULT, $random(seed));  // Result register ignores writes
    checkReg("scanline kept", `REG_SCANLINE, axilData_t'(shScan));
    checkReg("ctrl kept", `REG_CTRL, axilData_t'(shCtrl));
    checkReg("bitmap kept", `REG_BITMAP, axilData_t'(shBitmap));
    checkReg("attr kept", `REG_ATTR, axilData_t'(shAttr));
    endTest("register access");

    beginTest();
    for (int s = 0; s < 16; s++) begin
      writeReg(`REG_ATTR, $random(seed) & 32'h0000_0007);  // y bits only
      writeReg(`REG_SCANLINE, s);
      checkResult(blinkPh, cursorPh);
    end
    endTest("scanline mapping");

    beginTest();
    for (int i = 0; i < 24; i++) begin
      writeReg(`REG_BITMAP, $random(seed));
      writeReg(`REG_ATTR, $random(seed) & 32'h0000_073F);
      writeReg(`REG_CTRL, $random(seed) & 32'h0000_0010);  // Line enable only
      case (i % 4)
        0: value = 0;
        1: value = 7;
        2: value = 14;
        default: value = $random(seed);
      endcase
      writeReg(`REG_SCANLINE, value);
      checkResult(blinkPh, cursorPh);
    end
    endTest("row styling");

    beginTest();
    seenBlink = '0;
    seenCursor = '0;
    for (int i = 0; i < 64; i++) begin
      writeReg(`REG_CTRL, $random(seed) & 32'h0000_003F);
      writeReg(`REG_ATTR, $random(seed));
      pick = $unsigned($random(seed)) % 5;
      case (pick)
        0: value = 0;
        1: value = 1;
        2: value = 14;
        3: value = 15;
        default: value = $random(seed);
      endcase
      writeReg(`REG_SCANLINE, value);
      checkResult(blinkPh, cursorPh);
      seenBlink[blinkPh] = 1'b1;
      seenCursor[cursorPh] = 1'b1;
    end
    checkCount++;
    if (seenBlink != 2'b11 || seenCursor != 2'b11) begin
      errorCount++;
      $display("The phase timer did not show both phase values over 64 reads");
    end
    endTest("blink, hidden and cursor");

    beginTest();
    @(posedge clk);
    #10;
    value   = $random(seed);
    awvalid = 1'b1;
    awaddr  = `REG_ATTR;
    wvalid  = 1'b1;
    wdata   = value;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    #10;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b1;  // Must wait behind the held response
    araddr  = `REG_CTRL;
    repeat (5) begin
      @(negedge clk);
      checkData("bvalid held", 1, axilData_t'(bvalid));
      checkData("bresp held", '0, axilData_t'(bresp));
      checkData("arready blocked", '0, axilData_t'(arready));
    end
    @(posedge clk);
    #10;
    arvalid = 1'b0;
    bready  = 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    @(posedge clk);
    #10;
    bready = 1'b0;
    shAttr = attr_t'(value);
    transCount++;

    @(posedge clk);
    #10;
    arvalid = 1'b1;
    araddr  = `REG_BITMAP;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #10;
    arvalid = 1'b0;
    awvalid = 1'b1;  // Must not land while R is held
    awaddr  = `REG_SCANLINE;
    wvalid  = 1'b1;
    wdata   = axilData_t'(~shScan);
    heldData = axilData_t'(shBitmap);
    repeat (5) begin
      @(negedge clk);
      checkData("rvalid held", 1, axilData_t'(rvalid));
      checkData("rdata held", heldData, rdata);
      checkData("awready blocked", '0, axilData_t'(awready));
      checkData("wready blocked", '0, axilData_t'(wready));
    end
    @(posedge clk);
    #10;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    rready  = 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    @(posedge clk);
    #10;
    rready = 1'b0;
    transCount++;
    checkReg("scanline after blocked write", `REG_SCANLINE, axilData_t'(shScan));
    endTest("response back-pressure");

    $display("Summary: %0d tests, %0d transactions, %0d checks, %0d errors",
             testNum, transCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
stylerPkg.sv
styleCfgIf.sv
axilSlaveFsm.sv
styleRegs.sv
phaseTimer.sv
glyphStyler.sv
stylerTop.sv
tbStylerTop.sv

/* Bender.yml */
package:
  name: glyph_styler

sources:
  - include_dirs:
      - .
    files:
      - stylerPkg.sv
      - styleCfgIf.sv
      - axilSlaveFsm.sv
      - styleRegs.sv
      - phaseTimer.sv
      - glyphStyler.sv
      - stylerTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbStylerTop.sv
